// File: source/coreTypes.sv
`default_nettype none

package coreTypes;

  typedef logic [15:0] wordT;   // Data word
  typedef logic [2:0]  regIdxT; // Register index

  // Major opcode, instruction bits 15..11
  typedef enum logic [4:0] {
    opHalt  = 5'b00000,
    opNop   = 5'b00001,
    opAddi  = 5'b01000,
    opSubi  = 5'b01001,
    opXori  = 5'b01010,
    opAndni = 5'b01011,
    opSt    = 5'b10000,
    opLd    = 5'b10001,
    opSlbi  = 5'b10010,
    opLbi   = 5'b11000,
    opRtype = 5'b11011
  } opcodeT;

  // R-type function field, instruction bits 1..0
  typedef enum logic [1:0] {
    aluAdd  = 2'b00, // A + B
    aluSub  = 2'b01, // B - A
    aluXor  = 2'b10, // A ^ B
    aluAndn = 2'b11  // A & ~B
  } aluFuncT;

  // Field positions inside the instruction word
  localparam int OpLsb   = 11; // Opcode, 5 bits
  localparam int RsLsb   = 8;  // Rs, 3 bits
  localparam int RtLsb   = 5;  // Rt, 3 bits
  localparam int RdLsb   = 2;  // Rd for R-type, 3 bits
  localparam int FuncLsb = 0;  // ALU function for R-type, 2 bits

  localparam wordT nopWord = 16'h0800; // Bubble instruction

endpackage

`default_nettype wire

// File: source/pipeBus.sv
`timescale 1ns/1ps
`default_nettype none

// Decode to execute pipeline register contents
interface decodeExecBus;
  logic                valid;
  coreTypes::opcodeT   op;
  coreTypes::aluFuncT  func;
  coreTypes::wordT     operandA; // Rs as read in decode
  coreTypes::wordT     operandB; // Rt as read in decode
  coreTypes::wordT     imm;      // Extended immediate
  logic                useImm;
  coreTypes::regIdxT   rsSel;
  coreTypes::regIdxT   rtSel;
  coreTypes::regIdxT   destReg;
  logic                destEn;

  modport decode (
    output valid, op, func, operandA, operandB, imm, useImm,
    output rsSel, rtSel, destReg, destEn
  );

  modport execute (
    input valid, op, func, operandA, operandB, imm, useImm,
    input rsSel, rtSel, destReg, destEn
  );
endinterface

// Execute to result pipeline register contents
interface execResultBus;
  logic                valid;
  logic                isLoad;
  logic                isStore;
  coreTypes::regIdxT   destReg;
  logic                destEn;
  coreTypes::wordT     aluResult; // Also the memory address
  coreTypes::wordT     storeData;

  modport execute (
    output valid, isLoad, isStore, destReg, destEn, aluResult, storeData
  );

  modport result (
    input valid, isLoad, isStore, destReg, destEn, aluResult, storeData
  );
endinterface

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire                clk,
  input  wire                reset,
  input  wire coreTypes::regIdxT rdSelA,
  input  wire coreTypes::regIdxT rdSelB,
  input  wire coreTypes::regIdxT wrSel,
  input  wire coreTypes::wordT   wrData,
  input  wire                wrEn,
  output coreTypes::wordT        rdDataA,
  output coreTypes::wordT        rdDataB
);

  coreTypes::wordT regs [8];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrSel] <= wrData;
    end
  end

  // Write-through so a reader in the commit cycle sees the new value
  always_comb begin
    if (wrEn && (wrSel == rdSelA)) begin
      rdDataA = wrData;
    end else begin
      rdDataA = regs[rdSelA];
    end
  end

  always_comb begin
    if (wrEn && (wrSel == rdSelB)) begin
      rdDataB = wrData;
    end else begin
      rdDataB = regs[rdSelB];
    end
  end

endmodule

`default_nettype wire

// File: source/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  wire                    clk,
  input  wire                    reset,
  input  wire coreTypes::wordT   instruction,
  input  wire                    halted,
  input  wire                    commitEn,
  input  wire coreTypes::regIdxT commitReg,
  input  wire coreTypes::wordT   commitData,
  output logic                   stall,
  decodeExecBus.decode           bus
);

  // Unknown codes fall back to NOP
  function automatic coreTypes::opcodeT decodeOp(input logic [4:0] code);
    coreTypes::opcodeT result;
    case (code)
      coreTypes::opHalt, coreTypes::opNop, coreTypes::opAddi, coreTypes::opSubi,
      coreTypes::opXori, coreTypes::opAndni, coreTypes::opSt, coreTypes::opLd,
      coreTypes::opSlbi, coreTypes::opLbi, coreTypes::opRtype:
        result = coreTypes::opcodeT'(code);
      default: result = coreTypes::opNop;
    endcase
    return result;
  endfunction

  coreTypes::opcodeT  rawOp;     // Opcode at the input, for hazard check
  coreTypes::opcodeT  op;        // Opcode of the word going into the register
  coreTypes::wordT    decWord;
  coreTypes::aluFuncT func;
  coreTypes::wordT    imm;
  coreTypes::wordT    rdDataA;
  coreTypes::wordT    rdDataB;
  coreTypes::regIdxT  destReg;
  logic               destEn;
  logic               useImm;
  logic               readsRs;
  logic               readsRt;
  logic               accept;
  logic               haltPending; // HALT accepted, stop taking new words

  regFile regs (
    .clk     (clk),
    .reset   (reset),
    .rdSelA  (instruction[coreTypes::RsLsb +: 3]),
    .rdSelB  (instruction[coreTypes::RtLsb +: 3]),
    .wrSel   (commitReg),
    .wrData  (commitData),
    .wrEn    (commitEn),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  // Load-use check against the load sitting in the output register
  assign rawOp   = decodeOp(instruction[coreTypes::OpLsb +: 5]);
  assign readsRs = rawOp inside {coreTypes::opAddi, coreTypes::opSubi, coreTypes::opXori,
                                 coreTypes::opAndni, coreTypes::opSt, coreTypes::opLd,
                                 coreTypes::opSlbi, coreTypes::opRtype};
  assign readsRt = rawOp inside {coreTypes::opRtype, coreTypes::opSt};
  assign stall   = bus.valid && (bus.op == coreTypes::opLd) && bus.destEn &&
                   ((readsRs && (instruction[coreTypes::RsLsb +: 3] == bus.destReg)) ||
                    (readsRt && (instruction[coreTypes::RtLsb +: 3] == bus.destReg)));

  assign accept  = !stall && !halted && !haltPending;
  assign decWord = accept ? instruction : coreTypes::nopWord; // Bubble when not accepted
  assign op      = decodeOp(decWord[coreTypes::OpLsb +: 5]);

  always_comb begin
    func    = coreTypes::aluAdd;
    imm     = {{11{decWord[4]}}, decWord[4:0]}; // Signed imm5 unless overridden
    useImm  = 1'b1;
    destReg = decWord[coreTypes::RtLsb +: 3];
    destEn  = 1'b0;
    case (op)
      coreTypes::opRtype: begin
        func    = coreTypes::aluFuncT'(decWord[coreTypes::FuncLsb +: 2]);
        useImm  = 1'b0;
        destReg = decWord[coreTypes::RdLsb +: 3];
        destEn  = 1'b1;
      end
      coreTypes::opAddi, coreTypes::opLd: destEn = 1'b1;
      coreTypes::opSubi: begin
        func   = coreTypes::aluSub;
        destEn = 1'b1;
      end
      coreTypes::opXori: begin
        func   = coreTypes::aluXor;
        imm    = {11'h000, decWord[4:0]};
        destEn = 1'b1;
      end
      coreTypes::opAndni: begin
        func   = coreTypes::aluAndn;
        imm    = {11'h000, decWord[4:0]};
        destEn = 1'b1;
      end
      coreTypes::opLbi: begin
        imm     = {{8{decWord[7]}}, decWord[7:0]};
        destReg = decWord[coreTypes::RsLsb +: 3];
        destEn  = 1'b1;
      end
      coreTypes::opSlbi: begin
        imm     = {8'h00, decWord[7:0]};
        destReg = decWord[coreTypes::RsLsb +: 3];
        destEn  = 1'b1;
      end
      default: ; // Store, NOP and HALT write nothing
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bus.valid   <= 1'b0;
      bus.op      <= coreTypes::opNop;
      bus.destEn  <= 1'b0;
      haltPending <= 1'b0;
    end else begin
      bus.valid  <= accept;
      bus.op     <= op;
      bus.destEn <= destEn;
      if (accept && (op == coreTypes::opHalt)) begin
        haltPending <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    bus.func     <= func;
    bus.operandA <= rdDataA;
    bus.operandB <= rdDataB;
    bus.imm      <= imm;
    bus.useImm   <= useImm;
    bus.rsSel    <= decWord[coreTypes::RsLsb +: 3];
    bus.rtSel    <= decWord[coreTypes::RtLsb +: 3];
    bus.destReg  <= destReg;
  end

  // A stalled instruction leaves exactly one bubble behind it
  assert property (@(posedge clk) disable iff (reset) stall |=> !bus.valid);

endmodule

`default_nettype wire

// File: source/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  wire                    clk,
  input  wire                    reset,
  decodeExecBus.execute          inBus,
  execResultBus.execute          outBus,
  input  wire                    commitEn,
  input  wire coreTypes::regIdxT commitReg,
  input  wire coreTypes::wordT   commitData
);

  coreTypes::wordT fwdA;
  coreTypes::wordT fwdB;
  coreTypes::wordT srcB;
  coreTypes::wordT aluOut;
  coreTypes::wordT result;

  // Newest producer wins; a load in outBus never matches thanks to the stall
  function automatic coreTypes::wordT forward(input coreTypes::regIdxT sel,
                                              input coreTypes::wordT regValue);
    coreTypes::wordT value;
    if (outBus.valid && outBus.destEn && !outBus.isLoad && (outBus.destReg == sel)) begin
      value = outBus.aluResult;
    end else if (commitEn && (commitReg == sel)) begin
      value = commitData;
    end else begin
      value = regValue;
    end
    return value;
  endfunction

  assign fwdA = forward(inBus.rsSel, inBus.operandA);
  assign fwdB = forward(inBus.rtSel, inBus.operandB);
  assign srcB = inBus.useImm ? inBus.imm : fwdB;

  always_comb begin
    case (inBus.func)
      coreTypes::aluAdd:  aluOut = fwdA + srcB;
      coreTypes::aluSub:  aluOut = srcB - fwdA;
      coreTypes::aluXor:  aluOut = fwdA ^ srcB;
      coreTypes::aluAndn: aluOut = fwdA & ~srcB;
      default:            aluOut = fwdA + srcB;
    endcase
  end

  always_comb begin
    case (inBus.op)
      coreTypes::opLbi:  result = inBus.imm;
      coreTypes::opSlbi: result = {fwdA[7:0], 8'h00} | inBus.imm;
      default:           result = aluOut; // Also load/store address
    endcase
  end

  // NOPs drop out here, so a valid word with no effect downstream is a HALT
  always_ff @(posedge clk) begin
    if (reset) begin
      outBus.valid   <= 1'b0;
      outBus.isLoad  <= 1'b0;
      outBus.isStore <= 1'b0;
      outBus.destEn  <= 1'b0;
    end else begin
      outBus.valid   <= inBus.valid && (inBus.op != coreTypes::opNop);
      outBus.isLoad  <= inBus.valid && (inBus.op == coreTypes::opLd);
      outBus.isStore <= inBus.valid && (inBus.op == coreTypes::opSt);
      outBus.destEn  <= inBus.valid && inBus.destEn;
    end
  end

  always_ff @(posedge clk) begin
    outBus.destReg   <= inBus.destReg;
    outBus.aluResult <= result;
    outBus.storeData <= fwdB; // Rt value for stores
  end

  assert property (@(posedge clk) disable iff (reset) !(outBus.isLoad && outBus.isStore));

endmodule

`default_nettype wire

// File: source/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

module resultStage #(
  parameter int AddrWidth = 5
) (
  input  wire                   clk,
  input  wire                   reset,
  execResultBus.result          inBus,
  output logic                  commitEn,
  output coreTypes::regIdxT     commitReg,
  output coreTypes::wordT       commitData,
  output logic                  storeEn,
  output logic [AddrWidth-1:0]  storeAddr,
  output coreTypes::wordT       storeData,
  output logic                  halted
);

  localparam int Depth = 2 ** AddrWidth;

  coreTypes::wordT        mem [Depth];
  logic [AddrWidth-1:0]   memAddr;
  coreTypes::wordT        loadData;
  logic                   isHalt;

  assign memAddr  = inBus.aluResult[AddrWidth-1:0]; // Word address, high bits ignored
  assign loadData = mem[memAddr];
  assign isHalt   = inBus.valid && !inBus.isLoad && !inBus.isStore && !inBus.destEn;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < Depth; i++) begin
        mem[i] <= '0;
      end
      commitEn <= 1'b0;
      storeEn  <= 1'b0;
      halted   <= 1'b0;
    end else begin
      if (inBus.valid && inBus.isStore) begin
        mem[memAddr] <= inBus.storeData;
      end
      commitEn <= inBus.valid && inBus.destEn;
      storeEn  <= inBus.valid && inBus.isStore;
      if (isHalt) begin
        halted <= 1'b1; // Sticky until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    commitReg  <= inBus.destReg;
    commitData <= inBus.isLoad ? loadData : inBus.aluResult;
    storeAddr  <= memAddr;
    storeData  <= inBus.storeData;
  end

  assert property (@(posedge clk) disable iff (reset) !(commitEn && storeEn));

endmodule

`default_nettype wire

// File: source/coreTop.sv
`timescale 1ns/1ps
`default_nettype none

module coreTop #(
  parameter int AddrWidth = 5
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire coreTypes::wordT  instruction,
  output logic                  stall,
  output logic                  commitEn,
  output coreTypes::regIdxT     commitReg,
  output coreTypes::wordT       commitData,
  output logic                  storeEn,
  output logic [AddrWidth-1:0]  storeAddr,
  output coreTypes::wordT       storeData,
  output logic                  halted
);

  decodeExecBus decExec ();
  execResultBus execRes ();

  decodeStage decode (
    .clk         (clk),
    .reset       (reset),
    .instruction (instruction),
    .halted      (halted),
    .commitEn    (commitEn),   // Register file write port
    .commitReg   (commitReg),
    .commitData  (commitData),
    .stall       (stall),
    .bus         (decExec.decode)
  );

  executeStage execute (
    .clk        (clk),
    .reset      (reset),
    .inBus      (decExec.execute),
    .outBus     (execRes.execute),
    .commitEn   (commitEn),    // Forwarding source
    .commitReg  (commitReg),
    .commitData (commitData)
  );

  resultStage #(
    .AddrWidth (AddrWidth)
  ) result (
    .clk        (clk),
    .reset      (reset),
    .inBus      (execRes.result),
    .commitEn   (commitEn),
    .commitReg  (commitReg),
    .commitData (commitData),
    .storeEn    (storeEn),
    .storeAddr  (storeAddr),
    .storeData  (storeData),
    .halted     (halted)
  );

endmodule

`default_nettype wire

// File: sim/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb;

  localparam int AddrWidth     = 5;
  localparam int NumInstr      = 400;
  localparam int TimeoutCycles = 2 * NumInstr + 40;

  logic                 clk;
  logic                 reset;
  coreTypes::wordT      instruction;
  logic                 stall;
  logic                 commitEn;
  coreTypes::regIdxT    commitReg;
  coreTypes::wordT      commitData;
  logic                 storeEn;
  logic [AddrWidth-1:0] storeAddr;
  coreTypes::wordT      storeData;
  logic                 halted;

  integer seed = 32'h9013;
  int     cycle = 0;                 // Rising edges since time zero
  int     haltCycle = 32'h7fffffff;  // Edge at which halted must be seen
  int     lastLoadEdge = -10;        // Acceptance edge of the newest load
  coreTypes::regIdxT lastLoadDest;
  coreTypes::wordT   modelRegs [8];
  coreTypes::wordT   modelMem [2 ** AddrWidth];

  // Expected results in program order
  coreTypes::regIdxT    commitRegQ [$];
  coreTypes::wordT      commitDataQ [$];
  int                   commitCycleQ [$];
  logic [AddrWidth-1:0] storeAddrQ [$];
  coreTypes::wordT      storeDataQ [$];
  int                   storeCycleQ [$];

  coreTop #(.AddrWidth(AddrWidth)) DUT (
    .clk(clk), .reset(reset), .instruction(instruction), .stall(stall),
    .commitEn(commitEn), .commitReg(commitReg), .commitData(commitData),
    .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("Timeout: the program did not finish within %0d cycles", TimeoutCycles);
      abortRun();
    end
  end

  task automatic abortRun();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkCommit(input string testName, input coreTypes::regIdxT expReg,
                             input coreTypes::wordT expData, input coreTypes::regIdxT actReg,
                             input coreTypes::wordT actData);
    if ((actReg !== expReg) || (actData !== expData)) begin
      $display("[ERROR] %s: expected r%0d = %h, actual r%0d = %h",
               testName, expReg, expData, actReg, actData);
      abortRun();
    end
  endtask

  task automatic checkStore(input string testName, input logic [AddrWidth-1:0] expAddr,
                            input coreTypes::wordT expData, input logic [AddrWidth-1:0] actAddr,
                            input coreTypes::wordT actData);
    if ((actAddr !== expAddr) || (actData !== expData)) begin
      $display("[ERROR] %s: expected mem[%h] = %h, actual mem[%h] = %h",
               testName, expAddr, expData, actAddr, actData);
      abortRun();
    end
  endtask

  task automatic checkLevel(input string testName, input bit expLevel, input logic actLevel);
    if (actLevel !== expLevel) begin
      $display("[ERROR] %s: expected %b, actual %b", testName, expLevel, actLevel);
      abortRun();
    end
  endtask

  // Mostly r0..r3 so that producers and consumers sit close together
  function automatic coreTypes::regIdxT pickReg();
    logic [31:0] rv;
    rv = $random(seed);
    return (rv[3:0] < 4'd12) ? {1'b0, rv[5:4]} : rv[6:4];
  endfunction

  function automatic coreTypes::wordT makeInstr();
    int                pick;
    coreTypes::regIdxT rs;
    coreTypes::regIdxT rt;
    logic [7:0]        imm;
    coreTypes::wordT   word;
    pick = $unsigned($random(seed)) % 16;
    rs   = pickReg();
    rt   = pickReg();
    imm  = $random(seed);
    case (pick)
      0, 1, 2: word = {coreTypes::opLd, rs, rt, imm[4:0]};
      3, 4, 5: word = {coreTypes::opSt, rs, rt, imm[4:0]};
      6, 7:    word = {coreTypes::opRtype, rs, rt, pickReg(), imm[1:0]};
      8:       word = {coreTypes::opAddi, rs, rt, imm[4:0]};
      9:       word = {coreTypes::opSubi, rs, rt, imm[4:0]};
      10:      word = {coreTypes::opXori, rs, rt, imm[4:0]};
      11:      word = {coreTypes::opAndni, rs, rt, imm[4:0]};
      12, 13:  word = {coreTypes::opLbi, rs, imm};
      14:      word = {coreTypes::opSlbi, rs, imm};
      default: word = coreTypes::nopWord;
    endcase
    return word;
  endfunction

  function automatic bit readsReg(input coreTypes::wordT word, input coreTypes::regIdxT r);
    case (word[15:11])
      coreTypes::opAddi, coreTypes::opSubi, coreTypes::opXori, coreTypes::opAndni,
      coreTypes::opLd, coreTypes::opSlbi:  return word[10:8] == r;
      coreTypes::opSt, coreTypes::opRtype: return (word[10:8] == r) || (word[7:5] == r);
      default:                             return 1'b0;
    endcase
  endfunction

  // In-order reference model for one accepted instruction
  task automatic applyModel(input coreTypes::wordT word, input int accEdge);
    coreTypes::wordT      a;
    coreTypes::wordT      b;
    coreTypes::wordT      imm5s;
    coreTypes::wordT      imm5z;
    coreTypes::wordT      value;
    coreTypes::wordT      sum;
    coreTypes::regIdxT    dest;
    logic                 writes;
    a      = modelRegs[word[10:8]];
    b      = modelRegs[word[7:5]];
    imm5s  = {{11{word[4]}}, word[4:0]};
    imm5z  = {11'h000, word[4:0]};
    sum    = a + imm5s;  // Memory address for LD and ST
    dest   = word[7:5];
    writes = 1'b1;
    value  = '0;
    case (word[15:11])
      coreTypes::opAddi:  value = a + imm5s;
      coreTypes::opSubi:  value = imm5s - a;
      coreTypes::opXori:  value = a ^ imm5z;
      coreTypes::opAndni: value = a & ~imm5z;
      coreTypes::opLd:    value = modelMem[sum[AddrWidth-1:0]];
      coreTypes::opLbi: begin
        dest  = word[10:8];
        value = {{8{word[7]}}, word[7:0]};
      end
      coreTypes::opSlbi: begin
        dest  = word[10:8];
        value = {a[7:0], word[7:0]};
      end
      coreTypes::opRtype: begin
        dest = word[4:2];
        case (word[1:0])
          coreTypes::aluAdd: value = a + b;
          coreTypes::aluSub: value = b - a;
          coreTypes::aluXor: value = a ^ b;
          default:           value = a & ~b;
        endcase
      end
      coreTypes::opSt: begin
        writes = 1'b0;
        modelMem[sum[AddrWidth-1:0]] = b;
        storeAddrQ.push_back(sum[AddrWidth-1:0]);
        storeDataQ.push_back(b);
        storeCycleQ.push_back(accEdge + 3);
      end
      coreTypes::opHalt: begin
        writes    = 1'b0;
        haltCycle = accEdge + 3;
      end
      default: writes = 1'b0;  // NOP
    endcase
    if (writes) begin
      modelRegs[dest] = value;
      commitRegQ.push_back(dest);
      commitDataQ.push_back(value);
      commitCycleQ.push_back(accEdge + 3);
    end
  endtask

  // Outputs are sampled mid-cycle as the next rising edge will see them
  always @(negedge clk) begin
    if (!reset) begin
      checkLevel("halted", (cycle + 1) >= haltCycle, halted);
      checkLevel("commit timing", (commitCycleQ.size() > 0) && (commitCycleQ[0] == cycle + 1),
                 commitEn);
      checkLevel("store timing", (storeCycleQ.size() > 0) && (storeCycleQ[0] == cycle + 1),
                 storeEn);
      if (commitEn) begin
        checkCommit("commit", commitRegQ.pop_front(), commitDataQ.pop_front(),
                    commitReg, commitData);
        void'(commitCycleQ.pop_front());
      end
      if (storeEn) begin
        checkStore("store", storeAddrQ.pop_front(), storeDataQ.pop_front(),
                   storeAddr, storeData);
        void'(storeCycleQ.pop_front());
      end
    end
  end

  initial begin
    coreTypes::wordT word;
    bit              accepted;
    reset       = 1'b1;
    instruction = coreTypes::nopWord;
    foreach (modelRegs[i]) modelRegs[i] = '0;
    foreach (modelMem[i]) modelMem[i] = '0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int n = 0; n <= NumInstr; n++) begin
      word        = (n == NumInstr) ? {coreTypes::opHalt, 11'h000} : makeInstr();
      instruction = word;
      accepted    = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        checkLevel("load-use stall", (cycle == lastLoadEdge) && readsReg(word, lastLoadDest),
                   stall);
        if (!stall) begin
          accepted = 1'b1;
          applyModel(word, cycle + 1);
          if (word[15:11] == coreTypes::opLd) begin
            lastLoadEdge = cycle + 1;
            lastLoadDest = word[7:5];
          end
        end
        @(posedge clk);
        #2;
      end
    end
    instruction = {coreTypes::opLbi, 3'd1, 8'h5a};  // Register write that HALT must block
    while (!halted) @(negedge clk);
    repeat (6) @(negedge clk);  // Anything after HALT shows up as an extra commit
    if ((commitRegQ.size() == 0) && (storeAddrQ.size() == 0)) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("%0d commits and %0d stores never appeared",
               commitRegQ.size(), storeAddrQ.size());
      abortRun();
    end
  end

endmodule

`default_nettype wire

// File: tb.f
source/coreTypes.sv
source/pipeBus.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/coreTop.sv
sim/coreTb.sv

// File: Bender.yml
package:
  name: core16

sources:
  - source/coreTypes.sv
  - source/pipeBus.sv
  - source/regFile.sv
  - source/decodeStage.sv
  - source/executeStage.sv
  - source/resultStage.sv
  - source/coreTop.sv
  - target: test
    files:
      - sim/coreTb.sv
